//--- verilog/token_engine_pkg.sv
// lane count, data widths and pass configuration types for the token engine
// every RTL block imports this package
`default_nettype none

package token_engine_pkg;

    localparam int NUM_LANES  = 4;
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int WORD_BYTES = 4;
    localparam int BYTE_W     = DATA_W / WORD_BYTES;  // 8 bit weights
    localparam int BYTE_IDX_W = $clog2(WORD_BYTES);

    typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;
    typedef logic [DATA_W-1:0]            word_t;

    // word addresses, converted to bytes where the bus is driven
    typedef struct packed {
        logic [23:0] weight_base;
        logic [23:0] ifmap_base;
        logic [23:0] opsum_base;
        logic [7:0]  weight_words;
        logic [7:0]  ifmap_words;   // per lane
        logic [7:0]  opsum_words;   // per lane
        logic [7:0]  in_stride;     // words between lane rows
    } pass_cfg_t;

    typedef struct packed {
        logic              valid;
        logic [7:0]        pe_idx;  // running byte index over the pass
        logic [BYTE_W-1:0] data;
    } weight_beat_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WEIGHT_LOAD,
        ST_FIFO_INIT,
        ST_STREAM,
        ST_DONE
    } pass_state_e;

    function automatic logic [ADDR_W-1:0] word2byte(input logic [ADDR_W-1:0] word_addr);
        return word_addr * ADDR_W'(WORD_BYTES);
    endfunction

endpackage

`default_nettype wire

//--- verilog/glb_bus_pkg.sv
// Wishbone and internal GLB request/response types
// clients talk glb_req_t/glb_rsp_t, only the arbiter sees Wishbone
`default_nettype none

package glb_bus_pkg;

    import token_engine_pkg::*;

    // client 0 weight loader, 1..4 lane reads, 5..8 lane writes
    localparam int NUM_CLIENTS = 2 * NUM_LANES + 1;
    localparam int CLIENT_W    = $clog2(NUM_CLIENTS);

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [3:0]        sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_m2s_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_s2m_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] adr;    // byte address
        logic [DATA_W-1:0] wdata;
    } glb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } glb_rsp_t;

endpackage

`default_nettype wire

//--- verilog/pass_sequencer.sv
// top-level pass FSM, steps one pass through weight load, fifo init and stream
// its state output gates the weight loader and the lane controllers
`timescale 1ns/1ps
`default_nettype none

module pass_sequencer
    import token_engine_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 pass_start_i,
    input  logic                 weight_done_i,
    input  logic [NUM_LANES-1:0] lane_done_i,
    output pass_state_e          state_o,
    output logic                 fifo_reset_o,
    output logic                 pass_done_o
);

    pass_state_e state_q;
    pass_state_e state_d;
    logic        lanes_done;

    assign lanes_done = &lane_done_i;  // all lanes fetched and wrote back

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (pass_start_i) begin  // start only counts here
                    state_d = ST_WEIGHT_LOAD;
                end
            end
            ST_WEIGHT_LOAD: begin
                if (weight_done_i) begin
                    state_d = ST_FIFO_INIT;
                end
            end
            ST_FIFO_INIT: state_d = ST_STREAM;  // single cycle
            ST_STREAM: begin
                if (lanes_done) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o      = state_q;
    assign fifo_reset_o = (state_q == ST_FIFO_INIT);
    assign pass_done_o  = (state_q == ST_DONE);

endmodule

`default_nettype wire

//--- verilog/weight_loader.sv
// weight load step, reads the weight block word by word from the GLB
// and hands each word's bytes to the PE array, lowest byte first
`timescale 1ns/1ps
`default_nettype none

module weight_loader
    import token_engine_pkg::*;
    import glb_bus_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n_i,
    input  pass_state_e  state_i,
    input  pass_cfg_t    cfg_i,
    output glb_req_t     req_o,
    input  glb_rsp_t     rsp_i,
    output weight_beat_t weight_o,
    output logic         done_o
);

    logic                  active;
    logic                  started_q;
    logic                  req_q;
    logic                  emit_q;    // bytes of the held word going out
    logic                  done_q;
    logic [7:0]            word_cnt_q;
    logic [BYTE_IDX_W-1:0] byte_cnt_q;
    logic [7:0]            pe_idx_q;
    word_t                 shift_q;
    logic                  rd_ack;
    logic                  last_word;

    assign active    = (state_i == ST_WEIGHT_LOAD);
    assign rd_ack    = req_q & rsp_i.ack;
    assign last_word = (word_cnt_q == cfg_i.weight_words - 8'd1);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            started_q  <= 1'b0;
            req_q      <= 1'b0;
            emit_q     <= 1'b0;
            done_q     <= 1'b0;
            word_cnt_q <= '0;
            byte_cnt_q <= '0;
            pe_idx_q   <= '0;
        end else if (!active) begin
            started_q <= 1'b0;
            req_q     <= 1'b0;
            emit_q    <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!started_q) begin
                // first cycle of the phase, read goes out next cycle
                started_q  <= 1'b1;
                word_cnt_q <= '0;
                pe_idx_q   <= '0;
                req_q      <= (cfg_i.weight_words != 8'd0);
                done_q     <= (cfg_i.weight_words == 8'd0);  // nothing to load
            end else if (rd_ack) begin
                req_q      <= 1'b0;
                emit_q     <= 1'b1;
                byte_cnt_q <= '0;
            end else if (emit_q) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
                pe_idx_q   <= pe_idx_q + 8'd1;
                if (byte_cnt_q == BYTE_IDX_W'(WORD_BYTES - 1)) begin
                    emit_q     <= 1'b0;
                    word_cnt_q <= word_cnt_q + 8'd1;
                    if (last_word) begin
                        done_q <= 1'b1;
                    end else begin
                        req_q <= 1'b1;  // fetch the next word
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ack) begin
            shift_q <= rsp_i.rdata;
        end else if (emit_q) begin
            shift_q <= shift_q >> BYTE_W;
        end
    end

    always_comb begin
        req_o.req   = req_q;
        req_o.we    = 1'b0;
        req_o.adr   = word2byte(ADDR_W'(cfg_i.weight_base) + ADDR_W'(word_cnt_q));
        req_o.wdata = '0;
    end

    assign weight_o.valid  = emit_q;
    assign weight_o.pe_idx = pe_idx_q;
    assign weight_o.data   = shift_q[BYTE_W-1:0];
    assign done_o          = done_q;

endmodule

`default_nettype wire

//--- verilog/lane_fifo_ctrl.sv
// per-lane stream control, fetches ifmap words into the lane FIFO
// and writes the opsum FIFO back to the GLB under full/empty back-pressure
`timescale 1ns/1ps
`default_nettype none

module lane_fifo_ctrl
    import token_engine_pkg::*;
    import glb_bus_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  lane_idx_t   lane_i,
    input  pass_state_e state_i,
    input  logic        fifo_reset_i,
    input  pass_cfg_t   cfg_i,
    output glb_req_t    rd_req_o,
    input  glb_rsp_t    rd_rsp_i,
    output glb_req_t    wr_req_o,
    input  glb_rsp_t    wr_rsp_i,
    input  logic        ifmap_full_i,
    output logic        ifmap_push_o,
    output word_t       ifmap_data_o,
    input  logic        opsum_empty_i,
    input  word_t       opsum_data_i,
    output logic        opsum_pop_o,
    output logic        done_o
);

    logic [ADDR_W-1:0] ifmap_lane_base;
    logic [ADDR_W-1:0] opsum_lane_base;
    logic              active;
    logic              rd_more;
    logic              wr_more;
    logic              rd_ack;
    logic              wr_ack;
    logic              rd_req_q;
    logic              wr_req_q;
    logic              push_q;
    logic              done_q;
    logic [7:0]        rd_cnt_q;  // acked ifmap reads
    logic [7:0]        wr_cnt_q;  // acked opsum writes
    word_t             push_data_q;
    word_t             wr_data_q;

    // lane row offsets in word units
    assign ifmap_lane_base = ADDR_W'(cfg_i.ifmap_base)
                           + ADDR_W'(lane_i) * ADDR_W'(cfg_i.in_stride);
    assign opsum_lane_base = ADDR_W'(cfg_i.opsum_base)
                           + ADDR_W'(lane_i) * ADDR_W'(cfg_i.opsum_words);

    assign active  = (state_i == ST_STREAM);
    assign rd_more = (rd_cnt_q != cfg_i.ifmap_words);
    assign wr_more = (wr_cnt_q != cfg_i.opsum_words);
    assign rd_ack  = rd_req_q & rd_rsp_i.ack;
    assign wr_ack  = wr_req_q & wr_rsp_i.ack;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_req_q <= 1'b0;
            rd_cnt_q <= '0;
            push_q   <= 1'b0;
        end else if (fifo_reset_i) begin
            rd_req_q <= 1'b0;
            rd_cnt_q <= '0;
            push_q   <= 1'b0;
        end else begin
            push_q <= rd_ack;  // push one cycle after ack
            if (rd_ack) begin
                rd_req_q <= 1'b0;
                rd_cnt_q <= rd_cnt_q + 8'd1;
            end else if (active && !rd_req_q && !push_q && rd_more && !ifmap_full_i) begin
                // full flag is stale while a push is in flight
                rd_req_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_req_q <= 1'b0;
            wr_cnt_q <= '0;
        end else if (fifo_reset_i) begin
            wr_req_q <= 1'b0;
            wr_cnt_q <= '0;
        end else if (wr_ack) begin
            wr_req_q <= 1'b0;
            wr_cnt_q <= wr_cnt_q + 8'd1;
        end else if (active && !wr_req_q && wr_more && !opsum_empty_i) begin
            wr_req_q <= 1'b1;
        end
    end

    // held until fifo reset of the next pass
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q <= 1'b0;
        end else if (fifo_reset_i) begin
            done_q <= 1'b0;
        end else if (active && !rd_more && !wr_more && !push_q) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ack) begin
            push_data_q <= rd_rsp_i.rdata;
        end
        if (active && !wr_req_q && wr_more && !opsum_empty_i) begin
            wr_data_q <= opsum_data_i;  // fifo head, popped on ack
        end
    end

    always_comb begin
        rd_req_o.req   = rd_req_q;
        rd_req_o.we    = 1'b0;
        rd_req_o.adr   = word2byte(ifmap_lane_base + ADDR_W'(rd_cnt_q));
        rd_req_o.wdata = '0;
        wr_req_o.req   = wr_req_q;
        wr_req_o.we    = 1'b1;
        wr_req_o.adr   = word2byte(opsum_lane_base + ADDR_W'(wr_cnt_q));
        wr_req_o.wdata = wr_data_q;
    end

    assign ifmap_push_o = push_q;
    assign ifmap_data_o = push_data_q;
    assign opsum_pop_o  = wr_ack;
    assign done_o       = done_q;

endmodule

`default_nettype wire

//--- verilog/glb_arbiter.sv
// round-robin arbiter that shares the single Wishbone classic master
// between the weight loader and the lane read/write clients
`timescale 1ns/1ps
`default_nettype none

module glb_arbiter
    import token_engine_pkg::*;
    import glb_bus_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  glb_req_t [NUM_CLIENTS-1:0] req_i,
    output glb_rsp_t [NUM_CLIENTS-1:0] rsp_o,
    output wb_m2s_t                    wb_o,
    input  wb_s2m_t                    wb_i
);

    logic                busy_q;    // wishbone cycle in progress
    logic [CLIENT_W-1:0] grant_q;   // also the rotation pointer
    logic                pick_found;
    logic [CLIENT_W-1:0] pick_idx;
    logic                lat_we_q;
    logic [ADDR_W-1:0]   lat_adr_q;
    word_t               lat_dat_q;

    // search starts one past the client served last
    always_comb begin
        int unsigned cand;
        pick_found = 1'b0;
        pick_idx   = grant_q;
        for (int k = 1; k <= NUM_CLIENTS; k++) begin
            cand = int'(grant_q) + k;
            if (cand >= NUM_CLIENTS) begin
                cand = cand - NUM_CLIENTS;
            end
            if (!pick_found && req_i[cand].req) begin
                pick_found = 1'b1;
                pick_idx   = CLIENT_W'(cand);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            grant_q <= CLIENT_W'(NUM_CLIENTS - 1);  // client 0 wins first
        end else if (busy_q) begin
            if (wb_i.ack) begin
                busy_q <= 1'b0;  // cyc low for at least one cycle
            end
        end else if (pick_found) begin
            busy_q  <= 1'b1;
            grant_q <= pick_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && pick_found) begin
            lat_we_q  <= req_i[pick_idx].we;
            lat_adr_q <= req_i[pick_idx].adr;
            lat_dat_q <= req_i[pick_idx].wdata;
        end
    end

    always_comb begin
        wb_o.cyc = busy_q;
        wb_o.stb = busy_q;
        wb_o.we  = lat_we_q;
        wb_o.sel = '1;  // full word writes only
        wb_o.adr = lat_adr_q;
        wb_o.dat = lat_dat_q;
    end

    // ack and read data reach the granted client only
    always_comb begin
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            if (grant_q == CLIENT_W'(i)) begin
                rsp_o[i].ack   = busy_q & wb_i.ack;
                rsp_o[i].rdata = wb_i.dat;
            end else begin
                rsp_o[i].ack   = 1'b0;
                rsp_o[i].rdata = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/token_engine.sv
// token engine top, sequencer, weight loader, lane controllers and GLB arbiter
// GLB access goes out through one Wishbone classic master
`timescale 1ns/1ps
`default_nettype none

module token_engine
    import token_engine_pkg::*;
    import glb_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  pass_start_i,
    output logic                  pass_done_o,
    input  pass_cfg_t             cfg_i,
    output wb_m2s_t               wb_o,
    input  wb_s2m_t               wb_i,
    output logic [NUM_LANES-1:0]  ifmap_push_o,
    output word_t [NUM_LANES-1:0] ifmap_data_o,
    input  logic [NUM_LANES-1:0]  ifmap_full_i,
    output logic [NUM_LANES-1:0]  opsum_pop_o,
    input  logic [NUM_LANES-1:0]  opsum_empty_i,
    input  word_t [NUM_LANES-1:0] opsum_data_i,
    output logic                  fifo_reset_o,
    output weight_beat_t          weight_o
);

    pass_state_e                state;
    logic                       weight_done;
    logic [NUM_LANES-1:0]       lane_done;
    glb_req_t [NUM_CLIENTS-1:0] client_req;
    glb_rsp_t [NUM_CLIENTS-1:0] client_rsp;

    pass_sequencer u_pass_sequencer (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .pass_start_i  (pass_start_i),
        .weight_done_i (weight_done),
        .lane_done_i   (lane_done),
        .state_o       (state),
        .fifo_reset_o  (fifo_reset_o),
        .pass_done_o   (pass_done_o)
    );

    weight_loader u_weight_loader (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .state_i  (state),
        .cfg_i    (cfg_i),
        .req_o    (client_req[0]),
        .rsp_i    (client_rsp[0]),
        .weight_o (weight_o),
        .done_o   (weight_done)
    );

    // lane l reads on client 1+l, writes on client 1+NUM_LANES+l
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        lane_fifo_ctrl u_lane_fifo_ctrl (
            .clk           (clk),
            .arst_n_i      (arst_n_i),
            .lane_i        (lane_idx_t'(l)),
            .state_i       (state),
            .fifo_reset_i  (fifo_reset_o),
            .cfg_i         (cfg_i),
            .rd_req_o      (client_req[1 + l]),
            .rd_rsp_i      (client_rsp[1 + l]),
            .wr_req_o      (client_req[1 + NUM_LANES + l]),
            .wr_rsp_i      (client_rsp[1 + NUM_LANES + l]),
            .ifmap_full_i  (ifmap_full_i[l]),
            .ifmap_push_o  (ifmap_push_o[l]),
            .ifmap_data_o  (ifmap_data_o[l]),
            .opsum_empty_i (opsum_empty_i[l]),
            .opsum_data_i  (opsum_data_i[l]),
            .opsum_pop_o   (opsum_pop_o[l]),
            .done_o        (lane_done[l])
        );
    end

    glb_arbiter u_glb_arbiter (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (client_req),
        .rsp_o    (client_rsp),
        .wb_o     (wb_o),
        .wb_i     (wb_i)
    );

endmodule

`default_nettype wire

//--- testbench/tb_glb_model.sv
// Wishbone word memory with random wait states for the token engine testbench
// plus per-lane ifmap FIFO full flags and opsum FIFO sources
`timescale 1ns/1ps
`default_nettype none

module tb_glb_model
    import token_engine_pkg::*;
    import glb_bus_pkg::*;
(
    input  logic                  clk_i,
    input  wb_m2s_t               wb_i,
    output wb_s2m_t               wb_o,
    input  logic                  fifo_reset_i,
    input  logic [7:0]            opsum_words_i,
    input  logic [NUM_LANES-1:0]  opsum_pop_i,
    output logic [NUM_LANES-1:0]  ifmap_full_o,
    output logic [NUM_LANES-1:0]  opsum_empty_o,
    output word_t [NUM_LANES-1:0] opsum_data_o
);

    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] FILL_KEY  = 32'h5A5A_5A5A;

    word_t                mem [MEM_WORDS];
    logic [31:0]          lfsr       = 32'h15af_fada;
    wb_s2m_t              rsp_q      = '0;
    logic [NUM_LANES-1:0] full_q     = '0;
    logic [NUM_LANES-1:0] pop_seen_q = '0;
    logic [7:0]           pop_cnt [NUM_LANES] = '{default: '0};
    logic                 in_xfer    = 1'b0;
    logic [1:0]           wait_left  = '0;

    // fibonacci LFSR for x^32 + x^22 + x^2 + x + 1 with the new bit at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = 32'(a) ^ FILL_KEY;  // word address xor key
        end
    end

    always @(posedge clk_i) begin
        pop_seen_q <= opsum_pop_i;  // pop is high only up to the ack edge
    end

    always @(negedge clk_i) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            lfsr = lfsr_step(lfsr);
            full_q[l] <= lfsr[0];
            if (fifo_reset_i) begin
                pop_cnt[l] <= '0;
            end else if (pop_seen_q[l]) begin
                pop_cnt[l] <= pop_cnt[l] + 8'd1;
            end
        end
        if (rsp_q.ack) begin
            rsp_q.ack <= 1'b0;  // ack lasts one cycle
        end else if (wb_i.cyc && wb_i.stb) begin
            if (!in_xfer) begin
                in_xfer      = 1'b1;
                lfsr         = lfsr_step(lfsr);
                wait_left[0] = lfsr[0];
                lfsr         = lfsr_step(lfsr);
                wait_left[1] = lfsr[0];
            end
            if (wait_left == 2'd0) begin
                in_xfer   = 1'b0;
                rsp_q.ack <= 1'b1;
                if (wb_i.we) begin
                    mem[wb_i.adr[11:2]] = wb_i.dat;
                end else begin
                    rsp_q.dat <= mem[wb_i.adr[11:2]];
                end
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    assign wb_o         = rsp_q;
    assign ifmap_full_o = full_q;

    // opsum head value counts up with each pop
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            opsum_empty_o[l] = (pop_cnt[l] >= opsum_words_i);
            opsum_data_o[l]  = 32'hA000_0000 + 32'(l) * 32'h100 + 32'(pop_cnt[l]);
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_token_engine.sv
// testbench for the token engine, runs one pass per table row against the GLB model
// and checks weight bytes, lane pushes, opsum writeback and the Wishbone protocol
`timescale 1ns/1ps
`default_nettype none

module tb_token_engine
    import token_engine_pkg::*;
    import glb_bus_pkg::*;
();

    localparam int          CLK_PERIOD   = 40;
    localparam int          NUM_PASSES   = 4;
    localparam int          PASS_TIMEOUT = 5000;  // cycles
    localparam int          QUIET_CYCLES = 20;
    localparam logic [31:0] FILL_KEY     = 32'h5A5A_5A5A;

    typedef struct packed {
        pass_cfg_t   cfg;
        logic [15:0] exp_beats;  // 4 per weight word
        logic [15:0] exp_xfers;  // weight words + lanes x (ifmap + opsum)
    } pass_row_t;

    // cfg: weight_base, ifmap_base, opsum_base, weight/ifmap/opsum words, in_stride
    pass_row_t rows [NUM_PASSES] = '{
        '{'{24'h010, 24'h040, 24'h100, 8'd3, 8'd5, 8'd4, 8'd8},  16'd12, 16'd39},
        '{'{24'h020, 24'h080, 24'h140, 8'd1, 8'd2, 8'd6, 8'd3},  16'd4,  16'd33},
        '{'{24'h030, 24'h0c0, 24'h180, 8'd6, 8'd9, 8'd2, 8'd16}, 16'd24, 16'd50},
        '{'{24'h200, 24'h220, 24'h260, 8'd2, 8'd4, 8'd3, 8'd2},  16'd8,  16'd30}
    };

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  pass_start;
    pass_cfg_t             cfg;
    logic                  pass_done;
    wb_m2s_t               wb_m2s;
    wb_s2m_t               wb_s2m;
    logic [NUM_LANES-1:0]  ifmap_push;
    word_t [NUM_LANES-1:0] ifmap_data;
    logic [NUM_LANES-1:0]  ifmap_full;
    logic [NUM_LANES-1:0]  opsum_pop;
    logic [NUM_LANES-1:0]  opsum_empty;
    word_t [NUM_LANES-1:0] opsum_data;
    logic                  fifo_reset;
    weight_beat_t          weight;

    int          checks      = 0;
    int          errors      = 0;
    int          beat_idx    = 0;  // expected pe_idx of the next beat
    int          beat_total  = 0;
    int          xfer_total  = 0;
    int          done_total  = 0;
    int          reset_total = 0;
    int          push_idx   [NUM_LANES] = '{default: 0};
    int          push_total [NUM_LANES] = '{default: 0};
    int          pop_total  [NUM_LANES] = '{default: 0};
    logic        reset_seen = 1'b0;
    logic        prev_cyc   = 1'b0;
    logic        prev_we    = 1'b0;
    logic [31:0] prev_adr   = '0;
    logic [31:0] prev_dat   = '0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    token_engine u_dut (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .pass_start_i  (pass_start),
        .pass_done_o   (pass_done),
        .cfg_i         (cfg),
        .wb_o          (wb_m2s),
        .wb_i          (wb_s2m),
        .ifmap_push_o  (ifmap_push),
        .ifmap_data_o  (ifmap_data),
        .ifmap_full_i  (ifmap_full),
        .opsum_pop_o   (opsum_pop),
        .opsum_empty_i (opsum_empty),
        .opsum_data_i  (opsum_data),
        .fifo_reset_o  (fifo_reset),
        .weight_o      (weight)
    );

    tb_glb_model u_glb (
        .clk_i         (clk),
        .wb_i          (wb_m2s),
        .wb_o          (wb_s2m),
        .fifo_reset_i  (fifo_reset),
        .opsum_words_i (cfg.opsum_words),
        .opsum_pop_i   (opsum_pop),
        .ifmap_full_o  (ifmap_full),
        .opsum_empty_o (opsum_empty),
        .opsum_data_o  (opsum_data)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // weight and ifmap ranges for reads, opsum range for writes
    function automatic logic addr_in_pass(input logic [31:0] adr, input logic we,
                                          input pass_cfg_t c);
        int   w;
        int   base;
        int   l;
        logic hit;
        w   = int'(adr >> 2);
        hit = 1'b0;
        if (we) begin
            base = int'(c.opsum_base);
            hit  = (w >= base) && (w < base + NUM_LANES * int'(c.opsum_words));
        end else begin
            base = int'(c.weight_base);
            hit  = (w >= base) && (w < base + int'(c.weight_words));
            for (l = 0; l < NUM_LANES; l++) begin
                base = int'(c.ifmap_base) + l * int'(c.in_stride);
                if (w >= base && w < base + int'(c.ifmap_words)) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // all DUT outputs checked here are registered, stable at the falling edge
    always @(negedge clk) begin
        logic [31:0] exp_word;
        int          l;
        if (weight.valid) begin
            exp_word = (32'(cfg.weight_base) + 32'(beat_idx / WORD_BYTES)) ^ FILL_KEY;
            check_value("weight_o.data", 32'(weight.data),
                        32'(exp_word[8 * (beat_idx % WORD_BYTES) +: 8]));
            check_value("weight_o.pe_idx", 32'(weight.pe_idx), 32'(beat_idx));
            beat_idx++;
            beat_total++;
        end
        for (l = 0; l < NUM_LANES; l++) begin
            if (ifmap_push[l]) begin
                exp_word = (32'(cfg.ifmap_base) + 32'(l) * 32'(cfg.in_stride)
                         + 32'(push_idx[l])) ^ FILL_KEY;
                check_value($sformatf("ifmap_data_o[%0d]", l), ifmap_data[l], exp_word);
                check_value("fifo_reset_o before push", 32'(reset_seen), 32'd1);
                push_idx[l]++;
                push_total[l]++;
            end
        end
        if (fifo_reset) begin
            reset_total++;
            reset_seen = 1'b1;
            for (l = 0; l < NUM_LANES; l++) begin
                push_idx[l] = 0;
            end
        end
        if (pass_done) begin
            done_total++;
            reset_seen = 1'b0;
            beat_idx   = 0;
        end
        if (wb_m2s.cyc || wb_m2s.stb) begin
            check_value("wb_o.stb", 32'(wb_m2s.stb), 32'(wb_m2s.cyc));
            check_value("wb_o.sel", 32'(wb_m2s.sel), 32'hf);
            check_value("wb_o.adr[1:0]", 32'(wb_m2s.adr[1:0]), 32'd0);
            if (prev_cyc) begin
                check_value("wb_o.adr held", wb_m2s.adr, prev_adr);
                check_value("wb_o.we held", 32'(wb_m2s.we), 32'(prev_we));
                check_value("wb_o.dat held", wb_m2s.dat, prev_dat);
            end else begin
                xfer_total++;  // new transfer
                check_value("wb_o.adr in range",
                            32'(addr_in_pass(wb_m2s.adr, wb_m2s.we, cfg)), 32'd1);
            end
        end
        prev_cyc = wb_m2s.cyc;
        prev_we  = wb_m2s.we;
        prev_adr = wb_m2s.adr;
        prev_dat = wb_m2s.dat;
    end

    // pop follows ack combinationally and is gone after the rising edge
    always @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (opsum_pop[l]) begin
                pop_total[l] <= pop_total[l] + 1;
            end
        end
    end

    initial begin
        int   p;
        int   l;
        int   j;
        int   idx;
        int   waited;
        int   done_start;
        int   reset_start;
        int   beat_start;
        int   xfer_start;
        int   push_start [NUM_LANES];
        int   pop_start  [NUM_LANES];
        logic timed_out;
        arst_n     = 1'b0;
        pass_start = 1'b0;
        cfg        = '0;
        timed_out  = 1'b0;
        repeat (4) @(negedge clk);
        check_value("wb_o.cyc in reset", 32'(wb_m2s.cyc), 32'd0);
        check_value("wb_o.stb in reset", 32'(wb_m2s.stb), 32'd0);
        check_value("pass_done_o in reset", 32'(pass_done), 32'd0);
        check_value("fifo_reset_o in reset", 32'(fifo_reset), 32'd0);
        check_value("ifmap_push_o in reset", 32'(ifmap_push), 32'd0);
        check_value("opsum_pop_o in reset", 32'(opsum_pop), 32'd0);
        check_value("weight_o.valid in reset", 32'(weight.valid), 32'd0);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        for (p = 0; p < NUM_PASSES && !timed_out; p++) begin
            cfg         = rows[p].cfg;
            done_start  = done_total;
            reset_start = reset_total;
            beat_start  = beat_total;
            xfer_start  = xfer_total;
            for (l = 0; l < NUM_LANES; l++) begin
                push_start[l] = push_total[l];
                pop_start[l]  = pop_total[l];
            end
            pass_start = 1'b1;
            @(negedge clk);
            pass_start = 1'b0;
            repeat (3) @(negedge clk);
            pass_start = 1'b1;  // lands in weight load, must be ignored
            @(negedge clk);
            pass_start = 1'b0;
            waited = 0;
            while (!pass_done && waited < PASS_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!pass_done) begin
                $display("timeout: pass %0d gave no pass_done_o within %0d cycles",
                         p, PASS_TIMEOUT);
                errors++;
                timed_out = 1'b1;
            end else begin
                repeat (QUIET_CYCLES) @(negedge clk);
                check_value("pass_done_o pulses", 32'(done_total - done_start), 32'd1);
                check_value("fifo_reset_o pulses", 32'(reset_total - reset_start), 32'd1);
                check_value("weight_o beats", 32'(beat_total - beat_start),
                            32'(rows[p].exp_beats));
                check_value("wb_o transfers", 32'(xfer_total - xfer_start),
                            32'(rows[p].exp_xfers));
                for (l = 0; l < NUM_LANES; l++) begin
                    check_value($sformatf("ifmap_push_o[%0d] count", l),
                                32'(push_total[l] - push_start[l]), 32'(cfg.ifmap_words));
                    check_value($sformatf("opsum_pop_o[%0d] count", l),
                                32'(pop_total[l] - pop_start[l]), 32'(cfg.opsum_words));
                    for (j = 0; j < int'(cfg.opsum_words); j++) begin
                        idx = int'(cfg.opsum_base) + l * int'(cfg.opsum_words) + j;
                        check_value($sformatf("glb opsum word 0x%0h", idx), u_glb.mem[idx],
                                    32'hA000_0000 + 32'(l) * 32'h100 + 32'(j));
                    end
                end
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- token_engine.f
verilog/token_engine_pkg.sv
verilog/glb_bus_pkg.sv
verilog/pass_sequencer.sv
verilog/weight_loader.sv
verilog/lane_fifo_ctrl.sv
verilog/glb_arbiter.sv
verilog/token_engine.sv
testbench/tb_glb_model.sv
testbench/tb_token_engine.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_token_engine
FILELIST  ?= token_engine.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
